// ==== project.f ====
rtl/fetch_pkg.sv
rtl/cp0_pkg.sv
rtl/redirect_if.sv
rtl/pc_register.sv
rtl/fetch_ctrl.sv
rtl/pattern_history_table.sv
rtl/fetch_packet.sv
rtl/inst_fetch.sv
sim/icache_model.sv
sim/tb_inst_fetch.sv

// ==== run.sh ====
#!/bin/sh
# Build the fetch stage testbench with Verilator, run it, and judge the run by its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_inst_fetch -f project.f \
    -o tb_inst_fetch > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_inst_fetch > sim.log 2>&1 ; cat sim.log
grep -q "TESTS PASSED" sim.log && echo "run passed" || { echo "run failed"; exit 1; }

// ==== sim/tb_inst_fetch.sv ====
// Table driven testbench for the fetch stage with redirect, training and stall cases
`timescale 1ns/100ps

module tb_inst_fetch import fetch_pkg::*; ();

    localparam int    CLK_HALF        = 20;
    localparam int    RESET_CYCLES    = 5;
    localparam int    PHT_BITS        = 6;
    localparam int    STALL_CYCLES    = 12;
    localparam int    PKT_TIMEOUT     = 60;
    localparam int    NUM_TESTS       = 10;
    localparam int    TEST_BUDGET     = STALL_CYCLES + 2 * PKT_TIMEOUT + 10;
    localparam int    WATCHDOG_CYCLES = RESET_CYCLES + NUM_TESTS * TEST_BUDGET;
    localparam addr_t BOOT_PC         = 32'hBFC0_0000;

    typedef enum logic [1:0] {K_NEXT, K_FLUSH, K_EXC, K_STALL} kind_e;

    typedef struct packed {
        kind_e      kind;
        addr_t      target;
        addr_t      train_pc;
        logic       train_taken;
        logic [1:0] train_cnt;
        addr_t      exp_base;       // Unused for a stall
        slot_mask_t exp_mask;
        inst_num_t  exp_num;
        slot_mask_t exp_take;
        logic       exp_exc;
    } test_t;

    typedef struct packed {
        addr_t      base;
        slot_mask_t mask;
        inst_num_t  num;
        group_t     inst;
        slot_mask_t take;
        logic       exc;
        logic [4:0] code;
    } pkt_t;

    logic       clk, rst;
    logic       inst_req, index_ok, data_ok;
    addr_t      inst_index;
    group_t     rdata;
    logic       stop_fetch, exc_occur, flush, bra_valid, bra_taken;
    addr_t      exc_dest_pc, corr_dest, bra_pc;
    logic       if_valid, if_has_exc;
    addr_t      if_base_pc;
    slot_mask_t if_enable, if_take;
    inst_num_t  if_num;
    group_t     if_inst;
    logic [4:0] if_exc_code;

    test_t test_tab [NUM_TESTS];
    string test_name [NUM_TESTS];
    pkt_t  pkt_q [$];
    int    req_cnt;
    int    errors;
    addr_t next_base;       // Next sequential group of the expected stream

    inst_fetch #(
        .PHT_INDEX_BITS (PHT_BITS)
    ) uut (
        .clk_i (clk), .rst_i (rst),
        .inst_req_o (inst_req), .inst_index_o (inst_index),
        .inst_index_ok_i (index_ok), .inst_data_ok_i (data_ok), .inst_rdata_i (rdata),
        .ID_stopFetch_i (stop_fetch),
        .exc_occur_i (exc_occur), .exc_dest_pc_i (exc_dest_pc),
        .flush_i (flush), .corr_dest_i (corr_dest),
        .bra_valid_i (bra_valid), .bra_pc_i (bra_pc), .bra_taken_i (bra_taken),
        .IF_valid_o (if_valid), .IF_instBasePC_o (if_base_pc),
        .IF_instEnable_o (if_enable), .IF_instNum_o (if_num), .IF_inst_o (if_inst),
        .IF_predTake_o (if_take), .IF_hasException_o (if_has_exc), .IF_ExcCode_o (if_exc_code)
    );

    icache_model #(
        .SEED (81)
    ) u_icache_model (
        .clk_i (clk), .rst_i (rst), .req_i (inst_req), .index_i (inst_index),
        .index_ok_o (index_ok), .data_ok_o (data_ok), .rdata_o (rdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_HALF) clk = ~clk;
    end

    // Packets and requests sampled mid cycle
    initial begin
        forever begin
            @(negedge clk);
            if (!rst && if_valid) begin
                pkt_q.push_back(pkt_t'{if_base_pc, if_enable, if_num, if_inst,
                                       if_take, if_has_exc, if_exc_code});
            end
            if (!rst && inst_req) begin
                req_cnt++;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    ////////////////////
    // Helpers
    ////////////////////
    function automatic group_t expected_group(addr_t base);
        group_t g;
        for (int k = 0; k < 4; k++) begin
            g[k*32 +: 32] = (base + addr_t'(4 * k)) ^ 32'hA5A5_A5A5;
        end
        return g;
    endfunction

    task automatic compare(input string test, input string field,
                           input logic [127:0] expected, input logic [127:0] actual);
        if (expected !== actual) begin
            $display("error: %s %s expected %0h actual %0h", test, field, expected, actual);
            errors++;
        end
    endtask

    task automatic train_branch(input addr_t pc, input logic taken, input logic [1:0] count);
        repeat (count) begin
            @(posedge clk);
            bra_valid <= 1'b1;
            bra_pc    <= pc;
            bra_taken <= taken;
        end
        @(posedge clk);
        bra_valid <= 1'b0;
    endtask

    // Flush target differs so the exception target must win
    task automatic redirect(input logic with_exc, input addr_t target);
        @(posedge clk);
        exc_occur   <= with_exc;
        exc_dest_pc <= target;
        flush       <= 1'b1;
        corr_dest   <= with_exc ? target + 32'h0010_0000 : target;
        @(posedge clk);
        exc_occur <= 1'b0;
        flush     <= 1'b0;
        pkt_q.delete();         // Anything older belongs to the old stream
        req_cnt = 0;
    endtask

    task automatic stall_fetch(input string test);
        int seen;
        stop_fetch <= 1'b1;
        req_cnt = 0;
        repeat (STALL_CYCLES) @(posedge clk);
        seen = pkt_q.size();
        if (seen > 1) begin
            $display("test %s: %0d packets arrived while fetch was stopped", test, seen);
            errors++;
        end
        if (seen != 0) begin
            compare(test, "base while stopped", 128'(next_base), 128'(pkt_q[0].base));
            next_base = next_base + 32'd16;
            pkt_q.delete();
        end
        compare(test, "requests while stopped", 128'd0, 128'(req_cnt));
        stop_fetch <= 1'b0;
    endtask

    task automatic wait_packet(output logic got, output pkt_t pkt);
        int waited;
        waited = 0;
        got    = 1'b0;
        while (pkt_q.size() == 0 && waited < PKT_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (pkt_q.size() != 0) begin
            pkt = pkt_q.pop_front();
            got = 1'b1;
        end
    endtask

    ////////////////////
    // Test table
    ////////////////////
    task automatic build_table();
        test_name[0] = "boot group";
        test_tab[0]  = '{K_NEXT, 32'h0, 32'h0, 1'b0, 2'd0, BOOT_PC, 4'b1111, 3'd4, 4'b0000, 1'b0};
        test_name[1] = "second group";
        test_tab[1]  = '{K_NEXT, 32'h0, 32'h0, 1'b0, 2'd0, BOOT_PC + 32'd16,
                         4'b1111, 3'd4, 4'b0000, 1'b0};
        test_name[2] = "third group";
        test_tab[2]  = '{K_NEXT, 32'h0, 32'h0, 1'b0, 2'd0, BOOT_PC + 32'd32,
                         4'b1111, 3'd4, 4'b0000, 1'b0};
        test_name[3] = "exception beats flush";
        test_tab[3]  = '{K_EXC, 32'h0040_0000, 32'h0, 1'b0, 2'd0, 32'h0040_0000,
                         4'b1111, 3'd4, 4'b0000, 1'b0};
        test_name[4] = "flush mid group";
        test_tab[4]  = '{K_FLUSH, 32'h0000_0508, 32'h0, 1'b0, 2'd0, 32'h0000_0500,
                         4'b1100, 3'd2, 4'b0000, 1'b0};
        test_name[5] = "trained taken";     // Slot 2 of group 0x1000
        test_tab[5]  = '{K_FLUSH, 32'h0000_1000, 32'h0000_1008, 1'b1, 2'd2, 32'h0000_1000,
                         4'b1111, 3'd4, 4'b0100, 1'b0};
        test_name[6] = "trained not taken";
        test_tab[6]  = '{K_FLUSH, 32'h0000_1000, 32'h0000_1008, 1'b0, 2'd2, 32'h0000_1000,
                         4'b1111, 3'd4, 4'b0000, 1'b0};
        test_name[7] = "stall and resume";
        test_tab[7]  = '{K_STALL, 32'h0, 32'h0, 1'b0, 2'd0, 32'h0, 4'b1111, 3'd4, 4'b0000, 1'b0};
        test_name[8] = "misaligned target";
        test_tab[8]  = '{K_FLUSH, 32'h0000_2002, 32'h0, 1'b0, 2'd0, 32'h0000_2000,
                         4'b0000, 3'd0, 4'b0000, 1'b1};
        test_name[9] = "recover after error";
        test_tab[9]  = '{K_FLUSH, 32'h0000_3000, 32'h0, 1'b0, 2'd0, 32'h0000_3000,
                         4'b1111, 3'd4, 4'b0000, 1'b0};
    endtask

    initial begin
        test_t t;
        pkt_t  pkt;
        logic  got;
        addr_t exp_base;
        int    errs_before;
        int    passed;
        rst         = 1'b1;
        stop_fetch  = 1'b0;
        exc_occur   = 1'b0;
        exc_dest_pc = '0;
        flush       = 1'b0;
        corr_dest   = '0;
        bra_valid   = 1'b0;
        bra_pc      = '0;
        bra_taken   = 1'b0;
        req_cnt     = 0;
        errors      = 0;
        passed      = 0;
        next_base   = BOOT_PC;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < NUM_TESTS; i++) begin
            t           = test_tab[i];
            errs_before = errors;
            exp_base    = t.exp_base;
            if (t.train_cnt != 0) begin
                train_branch(t.train_pc, t.train_taken, t.train_cnt);
            end
            case (t.kind)
                K_FLUSH: redirect(1'b0, t.target);
                K_EXC:   redirect(1'b1, t.target);
                K_STALL: begin
                    stall_fetch(test_name[i]);
                    exp_base = next_base;       // Next sequential group
                end
                default: begin
                end
            endcase
            wait_packet(got, pkt);
            if (!got) begin
                $display("test %s: no packet arrived within %0d cycles",
                         test_name[i], PKT_TIMEOUT);
                errors++;
            end else begin
                compare(test_name[i], "base", 128'(exp_base), 128'(pkt.base));
                compare(test_name[i], "mask", 128'(t.exp_mask), 128'(pkt.mask));
                compare(test_name[i], "count", 128'(t.exp_num), 128'(pkt.num));
                compare(test_name[i], "exception", 128'(t.exp_exc), 128'(pkt.exc));
                if (t.exp_exc) begin
                    compare(test_name[i], "code", 128'd4, 128'(pkt.code));
                    compare(test_name[i], "requests", 128'd0, 128'(req_cnt));
                end else begin
                    compare(test_name[i], "words", 128'(expected_group(exp_base)), pkt.inst);
                    compare(test_name[i], "taken", 128'(t.exp_take), 128'(pkt.take));
                end
            end
            next_base = exp_base + 32'd16;
            if (errors == errs_before) begin
                passed++;
                $display("test %s ok", test_name[i]);
            end else begin
                $display("test %s failed", test_name[i]);
            end
        end

        $display("summary: %0d tests, %0d ok, %0d failed", NUM_TESTS, passed, NUM_TESTS - passed);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== sim/icache_model.sv ====
// Behavioral instruction cache that answers each accepted request after a random delay
`timescale 1ns/100ps

module icache_model import fetch_pkg::*; #(
    parameter int unsigned SEED = 81
) (
    input  logic   clk_i,
    input  logic   rst_i,
    input  logic   req_i,
    input  addr_t  index_i,
    output logic   index_ok_o,
    output logic   data_ok_o,
    output group_t rdata_o
);

    // Each word is its own address scrambled, slot 0 in the low word
    function automatic group_t group_words(addr_t base);
        group_t g;
        for (int k = 0; k < FETCH_WIDTH; k++) begin
            g[k*32 +: 32] = (base + addr_t'(4 * k)) ^ 32'hA5A5_A5A5;
        end
        return g;
    endfunction

    initial begin
        logic        busy;
        int unsigned wait_cycles;
        addr_t       addr_q;
        busy        = 1'b0;
        wait_cycles = 0;
        addr_q      = '0;
        index_ok_o  = 1'b0;
        data_ok_o   = 1'b0;
        rdata_o     = '0;
        void'($urandom(SEED));
        forever begin
            @(posedge clk_i);
            data_ok_o <= 1'b0;
            if (rst_i) begin
                busy = 1'b0;
                index_ok_o <= 1'b0;
            end else if (busy) begin
                if (wait_cycles == 0) begin
                    data_ok_o  <= 1'b1;
                    rdata_o    <= group_words(addr_q);
                    index_ok_o <= 1'b1;         // Ready for the next request
                    busy = 1'b0;
                end else begin
                    wait_cycles = wait_cycles - 1;
                end
            end else if (req_i && index_ok_o) begin
                addr_q      = index_i;          // Accept
                wait_cycles = $urandom % 4;
                busy        = 1'b1;
                index_ok_o <= 1'b0;
            end else begin
                index_ok_o <= 1'b1;
            end
        end
    end

endmodule

// ==== rtl/inst_fetch.sv ====
// Instruction fetch stage top with PC, cache handshake, branch history and packet
`timescale 1ns/100ps

module inst_fetch import fetch_pkg::*, cp0_pkg::*; #(
    parameter int PHT_INDEX_BITS = 6
) (
    input  logic       clk_i,
    input  logic       rst_i,
    // Instruction cache
    output logic       inst_req_o,
    output addr_t      inst_index_o,    // Group aligned
    input  logic       inst_index_ok_i,
    input  logic       inst_data_ok_i,
    input  group_t     inst_rdata_i,
    // Decode and redirect
    input  logic       ID_stopFetch_i,
    input  logic       exc_occur_i,
    input  addr_t      exc_dest_pc_i,
    input  logic       flush_i,
    input  addr_t      corr_dest_i,
    // Branch resolution
    input  logic       bra_valid_i,
    input  addr_t      bra_pc_i,
    input  logic       bra_taken_i,
    // Instruction queue
    output logic       IF_valid_o,
    output addr_t      IF_instBasePC_o,
    output slot_mask_t IF_instEnable_o,
    output inst_num_t  IF_instNum_o,
    output group_t     IF_inst_o,
    output slot_mask_t IF_predTake_o,
    output logic       IF_hasException_o,
    output exc_code_t  IF_ExcCode_o
);

    addr_t pc;
    logic  accept;
    logic  deliver;
    logic  addr_err;

    redirect_if redir ();

    assign redir.exc      = exc_occur_i;
    assign redir.exc_pc   = exc_dest_pc_i;
    assign redir.flush    = flush_i;
    assign redir.flush_pc = corr_dest_i;

    assign inst_index_o = group_base(pc);

    ////////////////////
    // PC and control
    ////////////////////
    pc_register u_pc_register (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .advance_i (accept),
        .redir     (redir.pc_mp),
        .pc_o      (pc)
    );

    fetch_ctrl u_fetch_ctrl (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .pc_i         (pc),
        .stop_fetch_i (ID_stopFetch_i),
        .index_ok_i   (inst_index_ok_i),
        .data_ok_i    (inst_data_ok_i),
        .redir        (redir.ctrl_mp),
        .inst_req_o   (inst_req_o),
        .accept_o     (accept),
        .deliver_o    (deliver),
        .addr_err_o   (addr_err)
    );

    ////////////////////
    // Prediction and packet
    ////////////////////
    pattern_history_table #(
        .PHT_INDEX_BITS (PHT_INDEX_BITS)
    ) u_pattern_history_table (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .read_i      (accept),
        .group_pc_i  (pc),
        .upd_valid_i (bra_valid_i),
        .upd_pc_i    (bra_pc_i),
        .upd_taken_i (bra_taken_i),
        .pred_take_o (IF_predTake_o)
    );

    fetch_packet u_fetch_packet (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .accept_i      (accept),
        .deliver_i     (deliver),
        .addr_err_i    (addr_err),
        .pc_i          (pc),
        .rdata_i       (inst_rdata_i),
        .valid_o       (IF_valid_o),
        .base_pc_o     (IF_instBasePC_o),
        .inst_enable_o (IF_instEnable_o),
        .inst_num_o    (IF_instNum_o),
        .inst_o        (IF_inst_o),
        .has_exc_o     (IF_hasException_o),
        .exc_code_o    (IF_ExcCode_o)
    );

endmodule

// ==== rtl/fetch_packet.sv ====
// Output packet builder capturing the accepted group for the instruction queue
`timescale 1ns/100ps

module fetch_packet import fetch_pkg::*, cp0_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       accept_i,
    input  logic       deliver_i,
    input  logic       addr_err_i,
    input  addr_t      pc_i,
    input  group_t     rdata_i,
    output logic       valid_o,
    output addr_t      base_pc_o,
    output slot_mask_t inst_enable_o,
    output inst_num_t  inst_num_o,
    output group_t     inst_o,
    output logic       has_exc_o,
    output exc_code_t  exc_code_o
);

    addr_t      acc_pc_q;       // PC of the request in flight
    logic [1:0] word_off;

    assign word_off = acc_pc_q[3:2];

    always_ff @(posedge clk_i) begin
        if (accept_i) begin
            acc_pc_q <= pc_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_o   <= 1'b0;
            has_exc_o <= 1'b0;
        end else begin
            valid_o <= deliver_i | addr_err_i;          // One cycle strobe
            if (deliver_i) begin
                has_exc_o <= 1'b0;
            end else if (addr_err_i) begin
                has_exc_o <= 1'b1;
            end
        end
    end

    // Slots before the entry word are not part of the stream
    always_ff @(posedge clk_i) begin
        if (deliver_i) begin
            base_pc_o     <= group_base(acc_pc_q);
            inst_enable_o <= slot_mask_t'('1) << word_off;
            inst_num_o    <= inst_num_t'(FETCH_WIDTH) - inst_num_t'(word_off);
            inst_o        <= rdata_i;
            exc_code_o    <= '0;
        end else if (addr_err_i) begin
            base_pc_o     <= group_base(pc_i);
            inst_enable_o <= '0;
            inst_num_o    <= '0;
            inst_o        <= '0;
            exc_code_o    <= EXC_ADEL;
        end
    end

endmodule

// ==== rtl/pattern_history_table.sv ====
// Pattern history table of 2-bit counters giving one taken bit per group slot
`timescale 1ns/100ps

module pattern_history_table import fetch_pkg::*; #(
    parameter int PHT_INDEX_BITS = 6
) (
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       read_i,
    input  addr_t      group_pc_i,
    input  logic       upd_valid_i,
    input  addr_t      upd_pc_i,
    input  logic       upd_taken_i,
    output slot_mask_t pred_take_o
);

    localparam int DEPTH = 1 << PHT_INDEX_BITS;

    typedef logic [PHT_INDEX_BITS-1:0] index_t;

    logic [1:0] counter_q [DEPTH];
    index_t     base_idx;
    index_t     upd_idx;
    logic [1:0] upd_cnt;

    // Word address of the group base, wraps with the table
    assign base_idx = group_pc_i[PHT_INDEX_BITS+1:2] & ~index_t'(FETCH_WIDTH - 1);
    assign upd_idx  = upd_pc_i[PHT_INDEX_BITS+1:2];
    assign upd_cnt  = counter_q[upd_idx];

    ////////////////////
    // Prediction read
    ////////////////////
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pred_take_o <= '0;
        end else if (read_i) begin
            for (int k = 0; k < FETCH_WIDTH; k++) begin
                pred_take_o[k] <= counter_q[base_idx + index_t'(k)][1];
            end
        end
    end

    ////////////////////
    // Training
    ////////////////////
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                counter_q[i] <= 2'b01;                  // Weakly not taken
            end
        end else if (upd_valid_i) begin
            if (upd_taken_i && upd_cnt != 2'b11) begin
                counter_q[upd_idx] <= upd_cnt + 2'd1;
            end else if (!upd_taken_i && upd_cnt != 2'b00) begin
                counter_q[upd_idx] <= upd_cnt - 2'd1;
            end
        end
    end

endmodule

// ==== rtl/fetch_ctrl.sv ====
// Fetch control FSM running the cache handshake and dropping cancelled requests
`timescale 1ns/100ps

module fetch_ctrl import fetch_pkg::*; (
    input  logic  clk_i,
    input  logic  rst_i,
    input  addr_t pc_i,
    input  logic  stop_fetch_i,
    input  logic  index_ok_i,
    input  logic  data_ok_i,
    redirect_if.ctrl_mp redir,
    output logic  inst_req_o,
    output logic  accept_o,
    output logic  deliver_o,
    output logic  addr_err_o
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_REQ,
        S_WAIT,
        S_DISCARD,      // Data still owed by the cache but no longer wanted
        S_HALT          // Address error reported, wait for redirect
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   redirect;
    logic   misaligned;

    assign redirect   = redir.exc | redir.flush;
    assign misaligned = |pc_i[1:0];

    // Request drops while decode is full
    assign inst_req_o = (state_q == S_REQ) & ~stop_fetch_i;
    assign accept_o   = inst_req_o & index_ok_i & ~redirect;
    assign deliver_o  = (state_q == S_WAIT) & data_ok_i & ~redirect;
    assign addr_err_o = (state_q == S_IDLE) & ~stop_fetch_i & misaligned & ~redirect;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (!redirect && !stop_fetch_i) begin
                    state_d = misaligned ? S_HALT : S_REQ;
                end
            end
            S_REQ: begin
                if (inst_req_o && index_ok_i) begin
                    state_d = redirect ? S_DISCARD : S_WAIT;    // Cache took it either way
                end else if (redirect) begin
                    state_d = S_IDLE;
                end
            end
            S_WAIT: begin
                if (data_ok_i) begin
                    state_d = redirect ? S_IDLE : S_REQ;
                end else if (redirect) begin
                    state_d = S_DISCARD;
                end
            end
            S_DISCARD: begin
                if (data_ok_i) begin
                    state_d = S_IDLE;
                end
            end
            S_HALT: begin
                if (redirect) begin
                    state_d = S_IDLE;
                end
            end
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

// ==== rtl/pc_register.sv ====
// Fetch PC register stepping through instruction groups and taking redirect targets
`timescale 1ns/100ps

module pc_register import fetch_pkg::*, cp0_pkg::*; (
    input  logic  clk_i,
    input  logic  rst_i,
    input  logic  advance_i,            // Cache accepted the current group
    redirect_if.pc_mp redir,
    output addr_t pc_o
);

    addr_t pc_q;
    addr_t pc_seq;
    addr_t pc_redir;

    // Next group always lands on a group boundary
    assign pc_seq = group_base(pc_q) + addr_t'(GROUP_BYTES);

    // Exception beats flush
    always_comb begin
        if (redir.exc) begin
            pc_redir = redir.exc_pc;
        end else begin
            pc_redir = redir.flush_pc;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_q <= RESET_VECTOR;
        end else if (redir.exc || redir.flush) begin
            pc_q <= pc_redir;
        end else if (advance_i) begin
            pc_q <= pc_seq;
        end
    end

    assign pc_o = pc_q;

endmodule

// ==== rtl/redirect_if.sv ====
// Redirect bundle carrying exception and branch flush targets into fetch
`timescale 1ns/100ps

interface redirect_if import fetch_pkg::*; ();

    logic  exc;         // Exception taken in the back end
    addr_t exc_pc;
    logic  flush;       // Branch mispredict
    addr_t flush_pc;

    // PC register picks the target
    modport pc_mp (
        input exc,
        input exc_pc,
        input flush,
        input flush_pc
    );

    // Control only needs to know that work in flight is dead
    modport ctrl_mp (
        input exc,
        input flush
    );

endinterface

// ==== rtl/cp0_pkg.sv ====
// Coprocessor 0 constants used by fetch, the reset vector and exception codes
package cp0_pkg;

    typedef logic [4:0] exc_code_t;

    // Address error on load or instruction fetch
    localparam exc_code_t EXC_ADEL = 5'd4;

    // Boot ROM entry in kseg1
    localparam logic [31:0] RESET_VECTOR = 32'hBFC0_0000;

endpackage

// ==== rtl/fetch_pkg.sv ====
// Fetch group geometry with the address, word and packet types of the fetch stage
package fetch_pkg;

    ////////////////////
    // Group geometry
    ////////////////////
    localparam int FETCH_WIDTH = 4;             // Instructions per group
    localparam int GROUP_BYTES = 16;

    ////////////////////
    // Types
    ////////////////////
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [FETCH_WIDTH-1:0] slot_mask_t;    // Enables and taken bits
    typedef logic [FETCH_WIDTH*32-1:0] group_t;    // Slot 0 in the low word
    typedef logic [2:0] inst_num_t;

    // Base address of the group holding pc
    function automatic addr_t group_base(addr_t pc);
        return pc & ~addr_t'(GROUP_BYTES - 1);
    endfunction

endpackage
